//--- bubbleEmu_cfg.svh
`ifndef BUBBLE_EMU_CFG_SVH
`define BUBBLE_EMU_CFG_SVH

// Bubble loop geometry
`define BUBBLE_POSITIONS    2053    // Positions 0 to 2052
`define INITIAL_POSITION    1464    // Lands on position 0 after the pre-roll

// Access lengths in bit slots
`define BOOT_OUT_LENGTH     4571
`define PAGE_OUT_LENGTH     703

// Bootloader windows
`define BOOT_START_SLOT     2641    // Two-slot start pattern
`define BOOT_DATA_FIRST     2643
`define BOOT_DATA_LAST      4562
`define BOOT_DUMMY_LAST     4568    // End of low dummy bits

// Page window
`define PAGE_DATA_FIRST     101
`define PAGE_DATA_LAST      612

// Buffer, bus and drive cycle
`define BUFFER_DEPTH        2048    // Two-bit pairs
`define SLOT_CYCLES         4       // Clocks per bit slot
`define PAIRS_PER_WORD      16      // Pairs in one AXI data word

`endif

//--- bubblePkg.sv
`include "bubbleEmu_cfg.svh"

package bubblePkg;

    // Drive-cycle events, one-cycle enables
    typedef struct packed {
        logic positionChange;   // Slot phase 0
        logic dataOutNotice;    // Replicator clamp
        logic dataOutStrobe;    // Bubble bit ready
        logic positionLatch;    // Page start marker
        logic pageSelect;       // High for page access
        logic coilRun;          // Active low while bubbles move
    } bubbleTimingT;

    // Serial bubble pins
    typedef struct packed {
        logic odd;
        logic even;
    } bubbleOutT;

    // Sequencer access state
    typedef enum logic [1:0] {
        standby,
        bootOut,
        pageOut
    } accessModeT;

    // One AXI word seen as control register or as buffer pairs
    typedef union packed {
        struct packed {
            logic [27:0] reserved;
            logic        busy;          // Read only
            logic        start;         // Self clearing
            logic        pageSelect;
            logic        moduleEnable;
        } ctrl;
        logic [`PAIRS_PER_WORD-1:0][1:0] pairs;     // Lane i at bits 2i+1 and 2i
    } bubbleWordU;

endpackage

//--- bubbleAxiLoader.sv
`timescale 1ns/1ns
`include "bubbleEmu_cfg.svh"

module bubbleAxiLoader
    import bubblePkg::*;
(
    input  logic        bubble_buffer_write_clock,
    input  logic        bufferDataOutCounterEnable,     // Async reset
    input  logic        awvalid,
    output logic        awready,
    input  logic [11:0] awaddr,
    input  logic        wvalid,
    output logic        wready,
    input  logic [31:0] wdata,
    output logic        bvalid,
    input  logic        bready,
    output logic [1:0]  bresp,
    input  logic        arvalid,
    output logic        arready,
    input  logic [11:0] araddr,
    output logic        rvalid,
    input  logic        rready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        bufWrite,
    output logic [10:0] bufWriteAddress,
    output logic [1:0]  bufWriteData,
    output logic        startPulse,
    output logic        pageSelect,
    output logic        moduleEnable,
    input  logic        busy
);

    localparam int LaneBits = $clog2(`PAIRS_PER_WORD);
    localparam int BaseBits = $clog2(`BUFFER_DEPTH) - LaneBits;
    localparam logic [LaneBits-1:0] LaneLast = LaneBits'(`PAIRS_PER_WORD - 1);
    localparam logic [9:0] BufferWords = 10'(`BUFFER_DEPTH / `PAIRS_PER_WORD);

    logic                awHandshake;
    logic                wHandshake;
    logic                awPending;         // AW taken, W outstanding
    logic [9:0]          writeAddrQ;        // Word index held from AW
    logic [9:0]          writeWordIndex;
    logic                isControlWord;
    logic                isBufferWord;
    bubbleWordU          writeWord;
    bubbleWordU          wordQ;             // Word being unpacked
    bubbleWordU          statusView;
    bubbleWordU          readWord;
    logic [BaseBits-1:0] bufferBase;        // Pair block of the word
    logic [LaneBits-1:0] laneCount;
    logic                unpacking;

    assign awHandshake    = awvalid & awready;
    assign wready         = (awready & awvalid) | awPending;  // W with or after AW
    assign wHandshake     = wvalid & wready;
    assign writeWordIndex = awPending ? writeAddrQ : awaddr[11:2];
    assign isControlWord  = (writeWordIndex == 10'd0);
    assign isBufferWord   = !isControlWord && (writeWordIndex <= BufferWords);
    assign writeWord      = bubbleWordU'(wdata);

    // Control view of the register, busy is live
    always_comb
    begin
        statusView                   = '0;
        statusView.ctrl.busy         = busy;
        statusView.ctrl.pageSelect   = pageSelect;
        statusView.ctrl.moduleEnable = moduleEnable;
    end

    always_ff @(posedge bubble_buffer_write_clock or posedge bufferDataOutCounterEnable)
    begin
        if (bufferDataOutCounterEnable)
        begin
            awready      <= 1'b1;
            awPending    <= 1'b0;
            bvalid       <= 1'b0;
            unpacking    <= 1'b0;
            laneCount    <= '0;
            startPulse   <= 1'b0;
            pageSelect   <= 1'b0;
            moduleEnable <= 1'b0;
            arready      <= 1'b1;
            rvalid       <= 1'b0;
        end
        else
        begin
            startPulse <= 1'b0;                         // One-cycle pulse
            if (awHandshake)
            begin
                awready <= 1'b0;                        // Held off until B completes
            end
            if (wHandshake)
            begin
                awPending <= 1'b0;
            end
            else if (awHandshake)
            begin
                awPending <= 1'b1;
            end
            if (wHandshake && isControlWord)
            begin
                moduleEnable <= writeWord.ctrl.moduleEnable;
                pageSelect   <= writeWord.ctrl.pageSelect;
                startPulse   <= writeWord.ctrl.start;
                bvalid       <= 1'b1;
            end
            else if (wHandshake && isBufferWord)
            begin
                unpacking <= 1'b1;                      // Sixteen pair writes follow
                laneCount <= '0;
            end
            else if (wHandshake)
            begin
                bvalid <= 1'b1;                         // Unmapped word dropped
            end
            if (unpacking)
            begin
                laneCount <= laneCount + 1'b1;
                if (laneCount == LaneLast)
                begin
                    unpacking <= 1'b0;
                    bvalid    <= 1'b1;                  // Cycle after last pair
                end
            end
            if (bvalid && bready)
            begin
                bvalid  <= 1'b0;
                awready <= 1'b1;
            end
            if (arvalid && arready)
            begin
                arready <= 1'b0;
                rvalid  <= 1'b1;
            end
            if (rvalid && rready)
            begin
                rvalid  <= 1'b0;
                arready <= 1'b1;
            end
        end
    end

    always_ff @(posedge bubble_buffer_write_clock)
    begin
        if (awHandshake)
        begin
            writeAddrQ <= awaddr[11:2];
        end
        if (wHandshake)
        begin
            wordQ      <= writeWord;
            bufferBase <= writeWordIndex[BaseBits-1:0] - BaseBits'(1);  // Word 1 is block 0
        end
        if (arvalid && arready)
        begin
            readWord <= (araddr[11:2] == 10'd0) ? statusView : '0;
        end
    end

    assign bufWrite        = unpacking;
    assign bufWriteAddress = {bufferBase, laneCount};
    assign bufWriteData    = wordQ.pairs[laneCount];
    assign bresp           = 2'b00;                     // Always OKAY
    assign rresp           = 2'b00;
    assign rdata           = readWord;

endmodule

//--- bubbleTimingGenerator.sv
`timescale 1ns/1ns
`include "bubbleEmu_cfg.svh"

module bubbleTimingGenerator
    import bubblePkg::*;
(
    input  logic         bubble_buffer_write_clock,
    input  logic         bufferDataOutCounterEnable,    // Async reset
    input  logic         startPulse,
    input  logic         pageSelect,                    // Access type at start
    output bubbleTimingT timing,
    output logic         busy
);

    localparam int PhaseBits = $clog2(`SLOT_CYCLES);
    localparam int SlotBits  = $clog2(`BOOT_OUT_LENGTH + 1);
    localparam logic [PhaseBits-1:0] PhaseLast = PhaseBits'(`SLOT_CYCLES - 1);
    localparam logic [PhaseBits-1:0] PhaseNotice = PhaseBits'(1);
    localparam logic [PhaseBits-1:0] PhaseStrobe = PhaseBits'(2);

    logic [PhaseBits-1:0] phase;            // Clock within the slot
    logic [SlotBits-1:0]  slot;             // 1 to access length
    logic [SlotBits-1:0]  accessLength;
    logic                 pageMode;         // Latched access type
    logic                 leadIn;           // Slot before slot 1
    logic                 slotEnd;

    assign accessLength = pageMode ? SlotBits'(`PAGE_OUT_LENGTH)
                                   : SlotBits'(`BOOT_OUT_LENGTH);
    assign slotEnd      = (phase == PhaseLast);

    always_ff @(posedge bubble_buffer_write_clock or posedge bufferDataOutCounterEnable)
    begin
        if (bufferDataOutCounterEnable)
        begin
            busy     <= 1'b0;
            pageMode <= 1'b0;
            leadIn   <= 1'b0;
            phase    <= '0;
            slot     <= '0;
        end
        else if (!busy)
        begin
            busy     <= startPulse;             // Start ignored while running
            pageMode <= pageSelect;
            leadIn   <= 1'b1;
            phase    <= '0;
            slot     <= '0;
        end
        else
        begin
            phase <= slotEnd ? '0 : phase + 1'b1;
            if (slotEnd && leadIn)
            begin
                leadIn <= 1'b0;
                slot   <= SlotBits'(1);
            end
            else if (slotEnd && (slot == accessLength))
            begin
                busy <= 1'b0;                   // Coil stops after last slot
            end
            else if (slotEnd)
            begin
                slot <= slot + 1'b1;
            end
        end
    end

    // Drive events decoded from phase and state
    always_comb
    begin
        timing.coilRun        = ~busy;                      // Low for the whole access
        timing.pageSelect     = busy & pageMode;
        timing.positionLatch  = busy & pageMode & leadIn & (phase == '0);
        timing.positionChange = busy & ~leadIn & (phase == '0);
        timing.dataOutNotice  = busy & ~leadIn & (phase == PhaseNotice);
        timing.dataOutStrobe  = busy & ~leadIn & (phase == PhaseStrobe);
    end

endmodule

//--- bubbleOutSequencer.sv
`timescale 1ns/1ns
`include "bubbleEmu_cfg.svh"

module bubbleOutSequencer
    import bubblePkg::*;
(
    input  logic         bubble_buffer_write_clock,
    input  logic         bufferDataOutCounterEnable,    // Async reset
    input  bubbleTimingT timing,
    input  logic         moduleEnable,
    input  logic         bufWrite,
    input  logic [10:0]  bufWriteAddress,
    input  logic [1:0]   bufWriteData,
    output bubbleOutT    bubbleOut,
    output logic         outValid,
    output logic [11:0]  bubblePosition,
    output logic         convert
);

    localparam int AddrBits  = $clog2(`BUFFER_DEPTH);
    localparam int CountBits = $clog2(`BOOT_OUT_LENGTH + 1);

    accessModeT           mode;
    logic [CountBits-1:0] noticeCount;      // Slots noticed
    logic [CountBits-1:0] bitCount;         // Slots strobed out
    logic [AddrBits-1:0]  readAddress;
    logic [AddrBits-1:0]  nextReadAddress;
    logic                 readWindow;
    logic [1:0]           bubbleBuffer [`BUFFER_DEPTH];
    logic [1:0]           readData;
    bubbleOutT            outMux;           // Before pin inversion

    // Mode from pageSelect, coilRun and positionLatch, glitch cases hold
    always_ff @(posedge bubble_buffer_write_clock or posedge bufferDataOutCounterEnable)
    begin
        if (bufferDataOutCounterEnable)
        begin
            mode <= standby;
        end
        else
        begin
            case ({timing.pageSelect, timing.coilRun, timing.positionLatch})
                3'b000:  mode <= bootOut;           // Bootloader running
                3'b010:  mode <= standby;           // Initial standby
                3'b101:  mode <= pageOut;           // Page start
                3'b110:  mode <= standby;           // Normal standby
                default: mode <= mode;              // Page hold or glitch
            endcase
        end
    end

    // Read window follows the notice count
    always_comb
    begin
        case (mode)
            bootOut: readWindow = (noticeCount >= `BOOT_DATA_FIRST) &&
                                  (noticeCount <= `BOOT_DATA_LAST);
            pageOut: readWindow = (noticeCount >= `PAGE_DATA_FIRST) &&
                                  (noticeCount <= `PAGE_DATA_LAST);
            default: readWindow = 1'b0;
        endcase
    end

    assign nextReadAddress = readAddress + 1'b1;    // Parked at all ones so first read is 0

    always_ff @(posedge bubble_buffer_write_clock or posedge bufferDataOutCounterEnable)
    begin
        if (bufferDataOutCounterEnable)
        begin
            noticeCount    <= '0;
            bitCount       <= '0;
            readAddress    <= '1;
            outValid       <= 1'b0;
            convert        <= 1'b0;
            bubblePosition <= 12'(`INITIAL_POSITION);
        end
        else
        begin
            outValid <= timing.dataOutStrobe;               // Slot result visible now
            convert  <= timing.positionLatch & timing.pageSelect;
            if (timing.positionChange)
            begin
                bubblePosition <= (bubblePosition < 12'(`BUBBLE_POSITIONS - 1))
                                  ? bubblePosition + 12'd1 : 12'd0;
            end
            if (mode == standby)
            begin
                noticeCount <= '0;
                bitCount    <= '0;
            end
            else
            begin
                if (timing.dataOutNotice && (noticeCount < `BOOT_OUT_LENGTH))
                begin
                    noticeCount <= noticeCount + 1'b1;
                end
                if (timing.dataOutStrobe && (bitCount < `BOOT_OUT_LENGTH))
                begin
                    bitCount <= bitCount + 1'b1;
                end
            end
            if (!readWindow)
            begin
                readAddress <= '1;
            end
            else if (timing.dataOutStrobe)
            begin
                readAddress <= nextReadAddress;
            end
        end
    end

    // Pair buffer, written from the bus side
    always_ff @(posedge bubble_buffer_write_clock)
    begin
        if (bufWrite)
        begin
            bubbleBuffer[bufWriteAddress] <= bufWriteData;
        end
        if (timing.dataOutStrobe && readWindow)
        begin
            readData <= bubbleBuffer[nextReadAddress];
        end
    end

    // Window rules on the bit count
    always_comb
    begin
        outMux = bubbleOutT'(2'b00);                        // Standby and bootloader high
        case (mode)
            bootOut:
            begin
                if (bitCount == `BOOT_START_SLOT)
                    outMux = bubbleOutT'(2'b01);            // Start pattern
                else if (bitCount == `BOOT_START_SLOT + 1)
                    outMux = bubbleOutT'(2'b11);
                else if ((bitCount >= `BOOT_DATA_FIRST) && (bitCount <= `BOOT_DATA_LAST))
                    outMux = bubbleOutT'(readData);
                else if ((bitCount > `BOOT_DATA_LAST) && (bitCount <= `BOOT_DUMMY_LAST))
                    outMux = bubbleOutT'(2'b11);            // Dummy bits low
            end
            pageOut:
            begin
                if ((bitCount >= `PAGE_DATA_FIRST) && (bitCount <= `PAGE_DATA_LAST))
                    outMux = bubbleOutT'(readData);
                else
                    outMux = bubbleOutT'(2'b11);            // Page filler low
            end
            default:
            begin
                outMux = bubbleOutT'(2'b00);
            end
        endcase
        bubbleOut = moduleEnable ? bubbleOutT'(~outMux) : bubbleOutT'(2'b00);
    end

endmodule

//--- bubbleEmulatorTop.sv
`timescale 1ns/1ns

module bubbleEmulatorTop
    import bubblePkg::*;
(
    input  logic        bubble_buffer_write_clock,
    input  logic        bufferDataOutCounterEnable,     // Async reset
    input  logic        awvalid,
    output logic        awready,
    input  logic [11:0] awaddr,
    input  logic        wvalid,
    output logic        wready,
    input  logic [31:0] wdata,
    output logic        bvalid,
    input  logic        bready,
    output logic [1:0]  bresp,
    input  logic        arvalid,
    output logic        arready,
    input  logic [11:0] araddr,
    output logic        rvalid,
    input  logic        rready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output bubbleOutT   bubbleOut,
    output logic        outValid,
    output logic [11:0] bubblePosition,
    output logic        convert
);

    logic         bufWrite;
    logic [10:0]  bufWriteAddress;
    logic [1:0]   bufWriteData;
    logic         startPulse;
    logic         pageSelect;
    logic         moduleEnable;
    logic         busy;
    bubbleTimingT timing;                   // Drive events to sequencer

    bubbleAxiLoader i_bubbleAxiLoader (
        .bubble_buffer_write_clock, .bufferDataOutCounterEnable,
        .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .bvalid, .bready, .bresp,
        .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
        .bufWrite, .bufWriteAddress, .bufWriteData,
        .startPulse, .pageSelect, .moduleEnable, .busy
    );

    bubbleTimingGenerator i_bubbleTimingGenerator (
        .bubble_buffer_write_clock, .bufferDataOutCounterEnable,
        .startPulse, .pageSelect, .timing, .busy
    );

    bubbleOutSequencer i_bubbleOutSequencer (
        .bubble_buffer_write_clock, .bufferDataOutCounterEnable,
        .timing, .moduleEnable, .bufWrite, .bufWriteAddress, .bufWriteData,
        .bubbleOut, .outValid, .bubblePosition, .convert
    );

endmodule

//--- bubbleEmulatorTb.sv
`timescale 1ns/1ns
`include "bubbleEmu_cfg.svh"

module bubbleEmulatorTb
    import bubblePkg::*;
();

    localparam logic [1:0] FillRandom = 2'd0;
    localparam logic [1:0] FillZero   = 2'd1;
    localparam logic [1:0] FillOnes   = 2'd2;
    localparam int RowCount    = 6;
    localparam int BufferWords = `BUFFER_DEPTH / `PAIRS_PER_WORD;

    typedef struct packed {
        logic       moduleEnable;
        logic       pageSelect;
        logic [1:0] fillKind;
    } accessRowT;

    // Accesses applied in order
    localparam accessRowT AccessTable [RowCount] = '{
        '{1'b1, 1'b1, FillRandom},          // Page with random pairs
        '{1'b1, 1'b0, FillRandom},          // Bootloader with random pairs
        '{1'b0, 1'b1, FillOnes},            // Disabled page
        '{1'b1, 1'b1, FillZero},
        '{1'b0, 1'b0, FillRandom},          // Disabled bootloader
        '{1'b1, 1'b1, FillOnes}
    };

    logic        bubble_buffer_write_clock;
    logic        bufferDataOutCounterEnable;
    logic        awvalid;
    logic        awready;
    logic [11:0] awaddr;
    logic        wvalid;
    logic        wready;
    logic [31:0] wdata;
    logic        bvalid;
    logic        bready;
    logic [1:0]  bresp;
    logic        arvalid;
    logic        arready;
    logic [11:0] araddr;
    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    bubbleOutT   bubbleOut;
    logic        outValid;
    logic [11:0] bubblePosition;
    logic        convert;

    logic [1:0]  refBuffer [`BUFFER_DEPTH];     // Model copy of the pair buffer
    logic [31:0] lcgState;
    logic [11:0] expPosition = 12'(`INITIAL_POSITION);
    int          slotCount = 0;                 // Slots seen since reset
    int          convertCount = 0;
    int          slotBase;                      // slotCount at access start
    logic        curPage;
    logic        curEnable;

    bubbleEmulatorTop i_bubbleEmulatorTop (
        .bubble_buffer_write_clock, .bufferDataOutCounterEnable,
        .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .bvalid, .bready, .bresp,
        .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
        .bubbleOut, .outValid, .bubblePosition, .convert
    );

    always #2 bubble_buffer_write_clock = ~bubble_buffer_write_clock;   // 4 ns period

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // Expected pins for one slot of an access
    function automatic bubbleOutT predictSlot(input int slot, input logic page,
                                              input logic enable);
        logic [1:0] bits;
        if (!enable)
            bits = 2'b00;
        else if (page && (slot >= `PAGE_DATA_FIRST) && (slot <= `PAGE_DATA_LAST))
            bits = ~refBuffer[11'(slot - `PAGE_DATA_FIRST)];
        else if (page)
            bits = 2'b00;                               // Page filler
        else if (slot == `BOOT_START_SLOT)
            bits = 2'b10;
        else if (slot == `BOOT_START_SLOT + 1)
            bits = 2'b00;
        else if ((slot >= `BOOT_DATA_FIRST) && (slot <= `BOOT_DATA_LAST))
            bits = ~refBuffer[11'(slot - `BOOT_DATA_FIRST)];
        else if ((slot > `BOOT_DATA_LAST) && (slot <= `BOOT_DUMMY_LAST))
            bits = 2'b00;                               // Dummy bits
        else
            bits = 2'b11;
        return bubbleOutT'(bits);
    endfunction

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic checkBubbleOut(input string name, input bubbleOutT got,
                                  input bubbleOutT expected);
        if (got !== expected)
            abortRun($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, expected));
    endtask

    task automatic checkWord(input string name, input bubbleWordU got,
                             input bubbleWordU expected);
        if (got !== expected)
            abortRun($sformatf("MISMATCH %s got 0x%08h expected 0x%08h", name, got, expected));
    endtask

    task automatic checkPosition(input string name, input logic [11:0] got,
                                 input logic [11:0] expected);
        if (got !== expected)
            abortRun($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, expected));
    endtask

    task automatic checkResp(input string name, input logic [1:0] got,
                             input logic [1:0] expected);
        if (got !== expected)
            abortRun($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, expected));
    endtask

    task automatic checkFlag(input string name, input logic got, input logic expected);
        if (got !== expected)
            abortRun($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, expected));
    endtask

    task automatic checkCount(input string name, input int got, input int expected);
        if (got != expected)
            abortRun($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, expected));
    endtask

    // Called right after a rising edge and returns after the B handshake
    task automatic axiWrite(input logic [11:0] addr, input logic [31:0] data);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wvalid  <= 1'b1;                                // AW and W together
        @(posedge bubble_buffer_write_clock);
        while (!awready)
            @(posedge bubble_buffer_write_clock);
        checkFlag("wready", wready, 1'b1);              // W taken with AW
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        @(posedge bubble_buffer_write_clock);
        while (!bvalid)
            @(posedge bubble_buffer_write_clock);
        checkResp("bresp", bresp, 2'b00);
    endtask

    task automatic axiRead(input logic [11:0] addr, output bubbleWordU word);
        araddr  <= addr;
        arvalid <= 1'b1;
        @(posedge bubble_buffer_write_clock);
        while (!arready)
            @(posedge bubble_buffer_write_clock);
        arvalid <= 1'b0;
        @(posedge bubble_buffer_write_clock);
        while (!rvalid)
            @(posedge bubble_buffer_write_clock);
        checkResp("rresp", rresp, 2'b00);
        word = bubbleWordU'(rdata);
    endtask

    task automatic runAccess(input accessRowT row);
        bubbleWordU fillWord;
        bubbleWordU ctrlWord;
        bubbleWordU readWord;
        int         length;
        int         convertBase;
        int         w;
        int         lane;
        length = row.pageSelect ? `PAGE_OUT_LENGTH : `BOOT_OUT_LENGTH;
        for (w = 0; w < BufferWords; w++)
        begin
            case (row.fillKind)
                FillZero: fillWord = '0;
                FillOnes: fillWord = '1;
                default:  fillWord = bubbleWordU'(nextRandom());
            endcase
            for (lane = 0; lane < `PAIRS_PER_WORD; lane++)
                refBuffer[11'(w * `PAIRS_PER_WORD + lane)] = fillWord.pairs[4'(lane)];
            axiWrite(12'((w + 1) * 4), fillWord);       // Word 1 holds pairs 0 to 15
        end
        curPage     = row.pageSelect;
        curEnable   = row.moduleEnable;
        slotBase    = slotCount;
        convertBase = convertCount;
        ctrlWord                   = '0;
        ctrlWord.ctrl.moduleEnable = row.moduleEnable;
        ctrlWord.ctrl.pageSelect   = row.pageSelect;
        ctrlWord.ctrl.start        = 1'b1;
        axiWrite(12'h000, ctrlWord);
        axiRead(12'h000, readWord);
        ctrlWord.ctrl.start = 1'b0;                     // Reads back as zero
        ctrlWord.ctrl.busy  = 1'b1;
        checkWord("rdata busy", readWord, ctrlWord);
        while (slotCount - slotBase < length)
            @(posedge bubble_buffer_write_clock);
        readWord.ctrl.busy = 1'b1;
        while (readWord.ctrl.busy)                      // Poll until idle
            axiRead(12'h000, readWord);
        ctrlWord.ctrl.busy = 1'b0;
        checkWord("rdata idle", readWord, ctrlWord);
        axiRead(12'h004, readWord);                     // Buffer words read as zero
        checkWord("rdata buffer word", readWord, bubbleWordU'(32'h0));
        @(negedge bubble_buffer_write_clock);
        checkBubbleOut("bubbleOut standby", bubbleOut,
                       bubbleOutT'(row.moduleEnable ? 2'b11 : 2'b00));
        checkCount("slot count", slotCount - slotBase, length);
        checkCount("convert pulses", convertCount - convertBase, row.pageSelect ? 1 : 0);
        @(posedge bubble_buffer_write_clock);
    endtask

    // Slot monitor sampling mid-cycle
    always @(negedge bubble_buffer_write_clock)
    begin
        if (outValid)
        begin
            slotCount   = slotCount + 1;
            expPosition = (expPosition == 12'(`BUBBLE_POSITIONS - 1)) ? 12'd0
                                                                      : expPosition + 12'd1;
            checkBubbleOut($sformatf("bubbleOut slot %0d", slotCount - slotBase), bubbleOut,
                           predictSlot(slotCount - slotBase, curPage, curEnable));
            checkPosition("bubblePosition", bubblePosition, expPosition);
        end
        if (convert)
            convertCount = convertCount + 1;
    end

    // Watchdog sized from the table
    initial
    begin
        int limitCycles;
        int r;
        limitCycles = 4000;
        for (r = 0; r < RowCount; r++)
            limitCycles = limitCycles + BufferWords * 32 + `SLOT_CYCLES *
                ((AccessTable[3'(r)].pageSelect ? `PAGE_OUT_LENGTH : `BOOT_OUT_LENGTH) + 1);
        repeat (limitCycles) @(posedge bubble_buffer_write_clock);
        abortRun("Watchdog expired before all accesses finished");
    end

    initial
    begin
        bubbleWordU readWord;
        int         row;
        bubble_buffer_write_clock  = 1'b0;
        bufferDataOutCounterEnable = 1'b1;
        awvalid   = 1'b0;
        awaddr    = '0;
        wvalid    = 1'b0;
        wdata     = '0;
        bready    = 1'b0;
        arvalid   = 1'b0;
        araddr    = '0;
        rready    = 1'b0;
        lcgState  = 32'hcb1b_7a7e;
        slotBase  = 0;
        curPage   = 1'b0;
        curEnable = 1'b0;
        repeat (5) @(posedge bubble_buffer_write_clock);
        bufferDataOutCounterEnable <= 1'b0;
        bready <= 1'b1;                                 // Responses always taken
        rready <= 1'b1;
        @(negedge bubble_buffer_write_clock);
        checkFlag("awready", awready, 1'b1);
        checkFlag("arready", arready, 1'b1);
        checkFlag("wready", wready, 1'b0);
        checkFlag("bvalid", bvalid, 1'b0);
        checkFlag("rvalid", rvalid, 1'b0);
        checkFlag("outValid", outValid, 1'b0);
        checkFlag("convert", convert, 1'b0);
        checkBubbleOut("bubbleOut reset", bubbleOut, bubbleOutT'(2'b00));
        checkPosition("bubblePosition reset", bubblePosition, 12'(`INITIAL_POSITION));
        @(posedge bubble_buffer_write_clock);
        axiRead(12'h000, readWord);
        checkWord("rdata reset", readWord, bubbleWordU'(32'h0));
        for (row = 0; row < RowCount; row++)
            runAccess(AccessTable[3'(row)]);
        $display("Test passed");
        $finish;
    end

endmodule

//--- sources.f
+incdir+.
bubblePkg.sv
bubbleAxiLoader.sv
bubbleTimingGenerator.sv
bubbleOutSequencer.sv
bubbleEmulatorTop.sv
bubbleEmulatorTb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
LINTFLAGS := --lint-only -Wall --timing
TOP       := bubbleEmulatorTb
FILELIST  := sources.f
OBJDIR    := obj_dir
LOG       := sim.log
PASSTEXT  := Test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASSTEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
